//--- verilog/tsp_pkg.sv
package tsp_pkg;

	typedef logic [7:0]  ts_byte_t;
	typedef logic [12:0] pid_t;
	typedef logic [7:0]  reg_addr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [1:0]  filter_idx_t;
	typedef logic [5:0]  word_idx_t;   // 0..46 within a packet.
	typedef logic [7:0]  byte_pos_t;   // 0..187 within a packet.

	localparam int PKT_BYTES   = 188;
	localparam int PKT_WORDS   = 47;
	localparam int NUM_FILTERS = 4;
	localparam int DELAY_BYTES = 6;   // enough to resolve the pid before byte 0 leaves.

	localparam reg_addr_t ADDR_INDEX        = 8'd0;
	localparam reg_addr_t ADDR_PID          = 8'd1;   // bit 16 enable, 12..0 pid.
	localparam reg_addr_t ADDR_MODE         = 8'd2;   // 0 monitor, 1 replace.
	localparam reg_addr_t ADDR_READ_REQUEST = 8'd3;
	localparam reg_addr_t ADDR_DATA_BASE    = 8'd64;
	localparam reg_addr_t ADDR_DATA_END     = reg_addr_t'(ADDR_DATA_BASE + PKT_WORDS - 1);

	typedef struct packed {
		logic     valid;
		logic     sync;
		ts_byte_t data;
	} ts_beat_t;

	typedef struct packed {
		logic enable;
		logic replace;
		pid_t pid;
	} filter_entry_t;

	typedef filter_entry_t [NUM_FILTERS-1:0] filter_table_t;

	typedef struct packed {
		logic hit_monitor;
		logic hit_replace;
	} match_t;

	typedef struct packed {
		logic      valid;
		word_idx_t idx;
		reg_data_t data;
	} buf_wr_t;

	typedef enum logic [1:0] {MON_IDLE, MON_ARMED, MON_READY} mon_state_t;

endpackage

//--- verilog/tsp_regs.sv
`timescale 1ns/1ps

module tsp_regs (
	input  logic                   mpeg_clk,
	input  logic                   rst_n,
	input  logic                   wen,
	input  tsp_pkg::reg_addr_t     waddr,
	input  tsp_pkg::reg_data_t     wdata,
	input  logic                   ren,
	input  tsp_pkg::reg_addr_t     raddr,
	output tsp_pkg::reg_data_t     rdata,
	output tsp_pkg::filter_table_t filter_table,
	output tsp_pkg::buf_wr_t       buf_wr,
	output logic                   armed,
	input  logic                   capture_done,
	output tsp_pkg::word_idx_t     cap_raddr,
	input  tsp_pkg::reg_data_t     cap_rdata
);
	tsp_pkg::filter_idx_t   sel_idx;
	tsp_pkg::filter_entry_t sel_entry;
	tsp_pkg::mon_state_t    mon_state;
	tsp_pkg::reg_data_t     rd_mux;
	logic                   arm;
	logic                   rd_in_buf;

	assign sel_entry = filter_table[sel_idx];
	assign arm = wen && (waddr == tsp_pkg::ADDR_READ_REQUEST);   // any write value arms.
	assign armed = (mon_state == tsp_pkg::MON_ARMED);

	assign buf_wr.valid = wen && (waddr >= tsp_pkg::ADDR_DATA_BASE) &&
		(waddr <= tsp_pkg::ADDR_DATA_END);
	assign buf_wr.idx = tsp_pkg::word_idx_t'(waddr - tsp_pkg::ADDR_DATA_BASE);
	assign buf_wr.data = wdata;

	assign rd_in_buf = (raddr >= tsp_pkg::ADDR_DATA_BASE) && (raddr <= tsp_pkg::ADDR_DATA_END);
	assign cap_raddr = tsp_pkg::word_idx_t'(raddr - tsp_pkg::ADDR_DATA_BASE);

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			sel_idx <= '0;
			for (int i = 0; i < tsp_pkg::NUM_FILTERS; i++) begin
				filter_table[i].enable <= 1'b0;
			end
		end else if (wen) begin
			case (waddr)
				tsp_pkg::ADDR_INDEX: sel_idx <= wdata[1:0];
				tsp_pkg::ADDR_PID: begin
					filter_table[sel_idx].enable <= wdata[16];
					filter_table[sel_idx].pid <= wdata[12:0];
				end
				tsp_pkg::ADDR_MODE: filter_table[sel_idx].replace <= wdata[0];
				default: ;
			endcase
		end
	end

	// the one-shot monitor is re-armed by another write.
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			mon_state <= tsp_pkg::MON_IDLE;
		end else begin
			case (mon_state)
				tsp_pkg::MON_IDLE:  if (arm) mon_state <= tsp_pkg::MON_ARMED;
				tsp_pkg::MON_ARMED: if (capture_done) mon_state <= tsp_pkg::MON_READY;
				tsp_pkg::MON_READY: if (arm) mon_state <= tsp_pkg::MON_ARMED;
				default: mon_state <= tsp_pkg::MON_IDLE;
			endcase
		end
	end

	always_comb begin
		rd_mux = '0;
		if (rd_in_buf) begin
			rd_mux = cap_rdata;   // capture buffer reads asynchronously.
		end else begin
			case (raddr)
				tsp_pkg::ADDR_INDEX: rd_mux = {30'b0, sel_idx};
				tsp_pkg::ADDR_PID: rd_mux = {15'b0, sel_entry.enable, 3'b0, sel_entry.pid};
				tsp_pkg::ADDR_MODE: rd_mux = {31'b0, sel_entry.replace};
				tsp_pkg::ADDR_READ_REQUEST: rd_mux = {31'b0, mon_state == tsp_pkg::MON_READY};
				default: ;
			endcase
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (ren) begin
			rdata <= rd_mux;   // held until the next read.
		end
	end

	// capture only starts while armed, so a done pulse with the monitor idle is lost state.
	a_done_not_idle: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		capture_done |-> (mon_state != tsp_pkg::MON_IDLE));

endmodule

//--- verilog/ts_framer.sv
`timescale 1ns/1ps

module ts_framer (
	input  logic              mpeg_clk,
	input  logic              rst_n,
	input  tsp_pkg::ts_beat_t in_beat,
	output tsp_pkg::ts_beat_t delayed_beat,
	output logic              pid_strobe,
	output tsp_pkg::pid_t     pid
);
	tsp_pkg::ts_beat_t  dly [tsp_pkg::DELAY_BYTES];
	tsp_pkg::byte_pos_t pos;       // position of the next byte.
	tsp_pkg::byte_pos_t cur_pos;
	logic               locked;
	logic [4:0]         pid_hi;

	assign cur_pos = in_beat.sync ? '0 : pos;

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			pos <= '0;
			locked <= 1'b0;
			pid_strobe <= 1'b0;
		end else begin
			pid_strobe <= 1'b0;
			if (in_beat.valid) begin
				if (in_beat.sync) begin
					locked <= 1'b1;
				end
				if (cur_pos == tsp_pkg::byte_pos_t'(tsp_pkg::PKT_BYTES - 1)) begin
					pos <= '0;
				end else begin
					pos <= cur_pos + 8'd1;
				end
				if (cur_pos == 8'd1) begin
					pid_hi <= in_beat.data[4:0];
				end
				if (locked && cur_pos == 8'd2) begin
					pid <= {pid_hi, in_beat.data};
					pid_strobe <= 1'b1;
				end
			end
		end
	end

	// delay advances only on accepted bytes.
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < tsp_pkg::DELAY_BYTES; i++) begin
				dly[i].valid <= 1'b0;
			end
			delayed_beat.valid <= 1'b0;
		end else begin
			delayed_beat.valid <= 1'b0;
			if (in_beat.valid) begin
				delayed_beat <= dly[tsp_pkg::DELAY_BYTES-1];   // empty slot keeps valid low.
				dly[0] <= in_beat;
				for (int i = 1; i < tsp_pkg::DELAY_BYTES; i++) begin
					dly[i] <= dly[i-1];
				end
			end
		end
	end

	a_sync_aligned: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		(in_beat.valid && in_beat.sync) |-> (!locked || pos == '0));

endmodule

//--- verilog/pid_matcher.sv
`timescale 1ns/1ps

module pid_matcher (
	input  logic                   mpeg_clk,
	input  logic                   rst_n,
	input  logic                   pid_strobe,
	input  tsp_pkg::pid_t          pid,
	input  tsp_pkg::filter_table_t filter_table,
	output tsp_pkg::match_t        match
);
	logic [tsp_pkg::NUM_FILTERS-1:0] hits;
	tsp_pkg::match_t                 hit_kind;

	always_comb begin
		for (int i = 0; i < tsp_pkg::NUM_FILTERS; i++) begin
			hits[i] = filter_table[i].enable && (filter_table[i].pid == pid);
		end
	end

	// walk down so the lowest index is applied last.
	always_comb begin
		hit_kind = '0;
		for (int i = tsp_pkg::NUM_FILTERS - 1; i >= 0; i--) begin
			if (hits[i]) begin
				hit_kind.hit_replace = filter_table[i].replace;
				hit_kind.hit_monitor = !filter_table[i].replace;
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			match <= '0;
		end else if (pid_strobe) begin
			match <= hit_kind;
		end
	end

endmodule

//--- verilog/packet_capture.sv
`timescale 1ns/1ps

module packet_capture (
	input  logic               mpeg_clk,
	input  logic               rst_n,
	input  tsp_pkg::ts_beat_t  delayed_beat,
	input  tsp_pkg::match_t    match,
	input  logic               armed,
	output logic               capture_done,
	input  tsp_pkg::word_idx_t cap_raddr,
	output tsp_pkg::reg_data_t cap_rdata
);
	tsp_pkg::reg_data_t mem [tsp_pkg::PKT_WORDS];
	tsp_pkg::byte_pos_t pos;
	tsp_pkg::byte_pos_t cur_pos;
	logic               capturing;
	logic               take;
	logic               last;

	assign cur_pos = delayed_beat.sync ? '0 : pos;
	assign last = (cur_pos == tsp_pkg::byte_pos_t'(tsp_pkg::PKT_BYTES - 1));
	// armed is still high in the done cycle, so block a back-to-back start.
	assign take = delayed_beat.valid && (delayed_beat.sync ?
		(armed && !capture_done && match.hit_monitor) : capturing);

	always_ff @(posedge mpeg_clk) begin
		if (take) begin
			mem[cur_pos[7:2]][{cur_pos[1:0], 3'b000} +: 8] <= delayed_beat.data;
		end
	end

	assign cap_rdata = mem[cap_raddr];

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			pos <= '0;
			capturing <= 1'b0;
			capture_done <= 1'b0;
		end else begin
			capture_done <= 1'b0;
			if (delayed_beat.valid) begin
				capturing <= take && !last;
				capture_done <= take && last;
				pos <= last ? '0 : cur_pos + 8'd1;
			end
		end
	end

endmodule

//--- verilog/packet_replacer.sv
`timescale 1ns/1ps

module packet_replacer (
	input  logic              mpeg_clk,
	input  logic              rst_n,
	input  tsp_pkg::ts_beat_t delayed_beat,
	input  tsp_pkg::match_t   match,
	input  tsp_pkg::buf_wr_t  buf_wr,
	output tsp_pkg::ts_byte_t ts_out,
	output logic              ts_out_valid,
	output logic              ts_out_sync
);
	tsp_pkg::reg_data_t mem [tsp_pkg::PKT_WORDS];
	tsp_pkg::reg_data_t buf_word;
	tsp_pkg::byte_pos_t pos;
	tsp_pkg::byte_pos_t cur_pos;
	logic               replacing;
	logic               use_buf;

	always_ff @(posedge mpeg_clk) begin
		if (buf_wr.valid) begin
			mem[buf_wr.idx] <= buf_wr.data;
		end
	end

	assign cur_pos = delayed_beat.sync ? '0 : pos;
	assign use_buf = delayed_beat.sync ? match.hit_replace : replacing;   // decided at byte 0.
	assign buf_word = mem[cur_pos[7:2]];

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			pos <= '0;
			replacing <= 1'b0;
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= delayed_beat.valid;
			ts_out_sync <= delayed_beat.valid && delayed_beat.sync;
			if (delayed_beat.valid) begin
				replacing <= use_buf;
				if (cur_pos == tsp_pkg::byte_pos_t'(tsp_pkg::PKT_BYTES - 1)) begin
					pos <= '0;
				end else begin
					pos <= cur_pos + 8'd1;
				end
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (delayed_beat.valid) begin
			ts_out <= use_buf ? buf_word[{cur_pos[1:0], 3'b000} +: 8] : delayed_beat.data;
		end
	end

endmodule

//--- verilog/tsp_top.sv
`timescale 1ns/1ps

module tsp_top (
	input  logic               mpeg_clk,
	input  logic               rst_n,
	input  logic               wen,
	input  tsp_pkg::reg_addr_t waddr,
	input  tsp_pkg::reg_data_t wdata,
	input  logic               ren,
	input  tsp_pkg::reg_addr_t raddr,
	output tsp_pkg::reg_data_t rdata,
	input  tsp_pkg::ts_byte_t  mpeg_data,
	input  logic               mpeg_valid,
	input  logic               mpeg_sync,
	output tsp_pkg::ts_byte_t  ts_out,
	output logic               ts_out_valid,
	output logic               ts_out_sync
);
	tsp_pkg::ts_beat_t      in_beat;
	tsp_pkg::ts_beat_t      delayed_beat;
	tsp_pkg::pid_t          pid;
	tsp_pkg::filter_table_t filter_table;
	tsp_pkg::buf_wr_t       buf_wr;
	tsp_pkg::match_t        match;
	tsp_pkg::word_idx_t     cap_raddr;
	tsp_pkg::reg_data_t     cap_rdata;
	logic                   pid_strobe;
	logic                   armed;
	logic                   capture_done;

	assign in_beat = {mpeg_valid, mpeg_sync, mpeg_data};

	tsp_regs tsp_regs_inst (
		.mpeg_clk, .rst_n, .wen, .waddr, .wdata, .ren, .raddr, .rdata,
		.filter_table, .buf_wr, .armed, .capture_done, .cap_raddr, .cap_rdata
	);

	ts_framer ts_framer_inst (
		.mpeg_clk, .rst_n, .in_beat, .delayed_beat, .pid_strobe, .pid
	);

	pid_matcher pid_matcher_inst (
		.mpeg_clk, .rst_n, .pid_strobe, .pid, .filter_table, .match
	);

	packet_capture packet_capture_inst (
		.mpeg_clk, .rst_n, .delayed_beat, .match, .armed, .capture_done,
		.cap_raddr, .cap_rdata
	);

	packet_replacer packet_replacer_inst (
		.mpeg_clk, .rst_n, .delayed_beat, .match, .buf_wr,
		.ts_out, .ts_out_valid, .ts_out_sync
	);

endmodule

//--- tests/tb_tsp.sv
`timescale 1ns/1ps

module tb_tsp;
	typedef enum logic [1:0] {PASS, REPLACE, CAPTURE} outcome_t;

	typedef struct packed {
		tsp_pkg::pid_t        pid;
		tsp_pkg::filter_idx_t idx;
		logic                 enable;
		logic                 replace;
		logic                 arm;
		outcome_t             outcome;
	} row_t;

	localparam int N_ROWS = 8;
	localparam int CYCLE_LIMIT = N_ROWS * tsp_pkg::PKT_BYTES * 2 + 600;

	// an armed row is never followed by another armed row.
	localparam row_t ROWS [N_ROWS] = '{
		'{13'h0100, 2'd0, 1'b0, 1'b0, 1'b0, PASS},
		'{13'h0100, 2'd0, 1'b1, 1'b1, 1'b0, REPLACE},
		'{13'h0101, 2'd1, 1'b0, 1'b0, 1'b0, PASS},
		'{13'h00ab, 2'd2, 1'b1, 1'b0, 1'b1, CAPTURE},
		'{13'h0100, 2'd0, 1'b0, 1'b1, 1'b0, PASS},
		'{13'h1234, 2'd3, 1'b1, 1'b1, 1'b0, REPLACE},
		'{13'h00ab, 2'd2, 1'b1, 1'b0, 1'b1, CAPTURE},
		'{13'h0055, 2'd1, 1'b0, 1'b0, 1'b0, PASS}
	};

	logic               mpeg_clk = 1'b0;
	logic               rst_n;
	logic               wen;
	logic               ren;
	logic               mpeg_valid;
	logic               mpeg_sync;
	logic               ts_out_valid;
	logic               ts_out_sync;
	tsp_pkg::reg_addr_t waddr;
	tsp_pkg::reg_addr_t raddr;
	tsp_pkg::reg_data_t wdata;
	tsp_pkg::reg_data_t rdata;
	tsp_pkg::ts_byte_t  mpeg_data;
	tsp_pkg::ts_byte_t  ts_out;

	tsp_pkg::ts_byte_t repl [tsp_pkg::PKT_BYTES];
	tsp_pkg::ts_byte_t cur_pkt [tsp_pkg::PKT_BYTES];
	tsp_pkg::ts_byte_t prev_pkt [tsp_pkg::PKT_BYTES];
	tsp_pkg::ts_byte_t out_data [$];
	logic              out_sync [$];
	int                cfg_err [N_ROWS];
	int                errors = 0;
	int                failed = 0;
	int                cycles = 0;
	int                mark;

	tsp_top tsp_top_inst (
		.mpeg_clk, .rst_n, .wen, .waddr, .wdata, .ren, .raddr, .rdata,
		.mpeg_data, .mpeg_valid, .mpeg_sync, .ts_out, .ts_out_valid, .ts_out_sync
	);

	always #10 mpeg_clk = ~mpeg_clk;

	always @(posedge mpeg_clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	always @(negedge mpeg_clk) begin
		if (ts_out_valid === 1'b1) begin
			out_data.push_back(ts_out);
			out_sync.push_back(ts_out_sync);
		end
	end

	task automatic check_byte(input string name, input tsp_pkg::ts_byte_t exp,
		input tsp_pkg::ts_byte_t got);
		if (got !== exp) begin
			$display("Error: %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input tsp_pkg::reg_data_t exp,
		input tsp_pkg::reg_data_t got);
		if (got !== exp) begin
			$display("Error: %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("Error: %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic reg_write(input tsp_pkg::reg_addr_t addr, input tsp_pkg::reg_data_t data);
		@(posedge mpeg_clk);
		#2;
		wen = 1'b1;
		waddr = addr;
		wdata = data;
		@(posedge mpeg_clk);
		#2;
		wen = 1'b0;
	endtask

	task automatic reg_read(input tsp_pkg::reg_addr_t addr, output tsp_pkg::reg_data_t data);
		@(posedge mpeg_clk);
		#2;
		ren = 1'b1;
		raddr = addr;
		@(posedge mpeg_clk);
		#2;
		ren = 1'b0;
		data = rdata;   // registered on the edge after ren.
	endtask

	task automatic configure_row(input row_t r);
		tsp_pkg::reg_data_t rd;
		tsp_pkg::reg_data_t pid_word;
		pid_word = {15'b0, r.enable, 3'b0, r.pid};
		reg_write(tsp_pkg::ADDR_INDEX, {30'b0, r.idx});
		reg_write(tsp_pkg::ADDR_PID, pid_word);
		reg_write(tsp_pkg::ADDR_MODE, {31'b0, r.replace});
		reg_read(tsp_pkg::ADDR_PID, rd);
		check_word("rdata ADDR_PID", pid_word, rd);
		reg_read(tsp_pkg::ADDR_MODE, rd);
		check_word("rdata ADDR_MODE", {31'b0, r.replace}, rd);
		if (r.arm) begin
			reg_write(tsp_pkg::ADDR_READ_REQUEST, 32'd1);
			reg_read(tsp_pkg::ADDR_READ_REQUEST, rd);
			check_word("rdata ADDR_READ_REQUEST", 32'd0, rd);
		end
	endtask

	task automatic send_packet(input tsp_pkg::pid_t pid);
		cur_pkt[0] = 8'h47;
		cur_pkt[1] = {3'b000, pid[12:8]};
		cur_pkt[2] = pid[7:0];
		for (int k = 3; k < tsp_pkg::PKT_BYTES; k++) begin
			cur_pkt[k] = tsp_pkg::ts_byte_t'($urandom);
		end
		for (int k = 0; k < tsp_pkg::PKT_BYTES; k++) begin
			@(posedge mpeg_clk);
			#2;
			mpeg_valid = 1'b1;
			mpeg_sync = (k == 0);
			mpeg_data = cur_pkt[k];
		end
		@(posedge mpeg_clk);
		#2;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
	endtask

	task automatic check_capture();
		tsp_pkg::reg_data_t rd;
		rd = '0;
		while (rd[0] !== 1'b1) begin
			reg_read(tsp_pkg::ADDR_READ_REQUEST, rd);
		end
		check_word("rdata ADDR_READ_REQUEST", 32'd1, rd);
		for (int w = 0; w < tsp_pkg::PKT_WORDS; w++) begin
			reg_read(tsp_pkg::reg_addr_t'(tsp_pkg::ADDR_DATA_BASE + w), rd);
			check_word($sformatf("rdata word %0d", 64 + w),
				{prev_pkt[4*w+3], prev_pkt[4*w+2], prev_pkt[4*w+1], prev_pkt[4*w]}, rd);
		end
	endtask

	// the row's packet has fully left the delay once the next packet is in.
	task automatic finish_row(input int i);
		tsp_pkg::ts_byte_t exp;
		int                start;
		start = errors;
		if (out_data.size() < tsp_pkg::PKT_BYTES) begin
			$display("Row %0d output is incomplete, only %0d bytes left the DUT", i,
				out_data.size());
			errors++;
		end else begin
			for (int k = 0; k < tsp_pkg::PKT_BYTES; k++) begin
				exp = (ROWS[i].outcome == REPLACE) ? repl[k] : prev_pkt[k];
				check_byte($sformatf("ts_out byte %0d", k), exp, out_data.pop_front());
				check_bit($sformatf("ts_out_sync byte %0d", k), k == 0, out_sync.pop_front());
			end
		end
		if (ROWS[i].outcome == CAPTURE) begin
			check_capture();
		end
		if (cfg_err[i] + errors - start != 0) begin
			failed++;
		end
		$display("row %0d %s: %s", i, ROWS[i].outcome.name(),
			(cfg_err[i] + errors - start == 0) ? "passed" : "failed");
	endtask

	initial begin
		void'($urandom(54));
		rst_n = 1'b0;
		wen = 1'b0;
		ren = 1'b0;
		waddr = '0;
		raddr = '0;
		wdata = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mpeg_data = '0;
		repeat (10) @(posedge mpeg_clk);
		#2;
		rst_n = 1'b1;
		for (int k = 0; k < tsp_pkg::PKT_BYTES; k++) begin
			repl[k] = (k == 0) ? 8'h47 : tsp_pkg::ts_byte_t'((k * 37 + 11) % 256);
		end
		for (int w = 0; w < tsp_pkg::PKT_WORDS; w++) begin
			reg_write(tsp_pkg::reg_addr_t'(tsp_pkg::ADDR_DATA_BASE + w),
				{repl[4*w+3], repl[4*w+2], repl[4*w+1], repl[4*w]});
		end
		for (int i = 0; i < N_ROWS; i++) begin
			mark = errors;
			configure_row(ROWS[i]);
			cfg_err[i] = errors - mark;
			prev_pkt = cur_pkt;
			send_packet(ROWS[i].pid);
			if (i > 0) begin
				finish_row(i - 1);
			end
		end
		prev_pkt = cur_pkt;
		send_packet(13'h1ffe);   // trailing packet pushes out the last row.
		finish_row(N_ROWS - 1);
		$display("%0d tests, %0d failed, %0d errors", N_ROWS, failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
verilog/tsp_pkg.sv
verilog/tsp_regs.sv
verilog/ts_framer.sv
verilog/pid_matcher.sv
verilog/packet_capture.sv
verilog/packet_replacer.sv
verilog/tsp_top.sv
tests/tb_tsp.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_tsp -f files.f &&
	./obj_dir/Vtb_tsp | tee /dev/stderr | grep -qx "Test OK" &&
	exit 0 ||
	{ echo "simulation did not pass"; exit 1; }
